// File: sim/program.hex
// one instruction word per line from word 0, assembly in the trailing comment
00500093 // addi x1, x0, 5
fff00113 // addi x2, x0, -1
002081b3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
00802283 // lw   x5, 8(x0)
00128333 // add  x6, x5, x1
00612623 // sw   x6, 12(x2)
123453b7 // lui  x7, 0x12345
00001417 // auipc x8, 0x1
00208863 // beq  x1, x2, 16
fe419ce3 // bne  x3, x4, -8
020000ef // jal  x1, 32
00008067 // jalr x0, 0(x1)
ffc12483 // lw   x9, -4(x2)
0074e533 // or   x10, x9, x7
07f57593 // andi x11, x10, 0x7f
feb02623 // sw   x11, -20(x0)
8062c063 // blt  x5, x6, -4096
fffff637 // lui  x12, 0xfffff
ffdff06f // jal  x0, -4
00309693 // slli x13, x1, 3
4026d713 // srai x14, x13, 2
00370783 // lb   x15, 3(x14)
00d7c833 // xor  x16, x15, x13
01079323 // sh   x16, 6(x15)
00082883 // lw   x17, 0(x16)
41188933 // sub  x18, x17, x17
7e097f63 // bgeu x18, x0, 2046
80000997 // auipc x19, 0x80000
7ffff0ef // jal  x1, 1048574
fff982e7 // jalr x5, -1(x19)
00000013 // addi x0, x0, 0

// File: fetchDecodeTop.f
rtl/rvFrontendPkg.sv
rtl/pcGenerator.sv
rtl/instructionMemory.sv
rtl/pipelineRegisterIfId.sv
rtl/instructionDecoder.sv
rtl/hazardDetection.sv
rtl/fetchDecodeTop.sv
sim/fetchDecodeTb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := fetchDecodeTb
FILELIST  := fetchDecodeTop.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/fetchDecodeTb.sv
`timescale 1ns/10ps

module fetchDecodeTb;
    import rvFrontendPkg::*;

    localparam int    progWords      = 32;  // words in program.hex
    localparam int    numSteps       = 600; // random cycles after startup
    localparam int    setupSteps     = 9;   // reset, idle, start pulse, waiting
    localparam int    clkPeriod      = 10;
    localparam int    watchdogCycles = (numSteps + setupSteps) * 20 + 50;
    localparam xlenT  lastPc         = xlenT'((progWords - 1) * 4);
    localparam fetchT bubble         = '{pc: resetPc, instr: nopInstr};

    logic     clk;
    logic     rstN;
    logic     startProcess;
    redirectT redirect;
    exLoadT   exLoad;
    decodedT  decoded;
    logic     stall;

    instrT progMem [imemDepth]; // own copy of the program

    // reference model state
    ifIdStateT mState;
    int        mWaitLeft;
    xlenT      mPc;
    fetchT     mFetch; // registered memory pair
    fetchT     mIfId;

    int      errCount;
    int      checkCount;
    int      redirectCount;
    int      stallCount;
    int      flushCount;   // redirect and stall in the same cycle
    decodedT prevDecoded;
    logic    holdNow;      // stall driven this cycle without a redirect
    logic    holdPrev;

    fetchDecodeTop fetchDecodeTop_inst (
        .clk          (clk),
        .rstN         (rstN),
        .startProcess (startProcess),
        .redirect     (redirect),
        .exLoad       (exLoad),
        .decoded      (decoded),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk; // 10 ns period
        end
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired, run still going after %0d cycles", watchdogCycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // reference decode straight from the RV32I base formats
    function automatic decodedT refDecode(fetchT f);
        decodedT            d;
        instrT              w;
        logic signed [11:0] imm12;
        logic signed [12:0] imm13;
        logic signed [20:0] imm21;
        w        = f.instr;
        d.pc     = f.pc;
        d.opcode = w[6:0];
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct7 = w[31:25];
        d.imm    = '0; // op and anything unknown
        if (w[6:0] == opLoad || w[6:0] == opOpImm || w[6:0] == opJalr) begin
            imm12 = w[31:20];
            d.imm = xlenT'(imm12);
        end else if (w[6:0] == opStore) begin
            imm12 = {w[31:25], w[11:7]};
            d.imm = xlenT'(imm12);
        end else if (w[6:0] == opBranch) begin
            imm13 = {w[31], w[7], w[30:25], w[11:8], 1'b0};
            d.imm = xlenT'(imm13);
        end else if (w[6:0] == opLui || w[6:0] == opAuipc) begin
            d.imm = {w[31:12], 12'h000};
        end else if (w[6:0] == opJal) begin
            imm21 = {w[31], w[19:12], w[20], w[30:21], 1'b0};
            d.imm = xlenT'(imm21);
        end
        return d;
    endfunction

    // EX load whose rd feeds a decode source with x0 excluded
    function automatic logic loadUseStall(decodedT d, exLoadT e);
        return e.memRead && (e.rd != 5'd0) && ((e.rd == d.rs1) || (e.rd == d.rs2));
    endfunction

    // one rising edge of the model with inputs as they stand at the edge
    task automatic modelEdge();
        logic running;
        logic held;
        xlenT nPc;
        running = (mState == working);
        held    = loadUseStall(refDecode(mIfId), exLoad);
        if (!running) begin
            nPc = resetPc;
        end else if (redirect.taken) begin
            nPc = redirect.target;
        end else if (held) begin
            nPc = mPc;
        end else begin
            nPc = mPc + xlenT'(4);
        end
        if (running && redirect.taken) begin
            mIfId = bubble; // flush wins
        end else if (running && !held) begin
            mIfId = mFetch;
        end
        mPc          = nPc;
        mFetch.pc    = nPc;
        mFetch.instr = progMem[nPc[imemAddrW+1:2]];
        if (mState == waiting) begin
            mWaitLeft--;
            if (mWaitLeft == 0) begin
                mState = working;
            end
        end else if (mState == idle && startProcess) begin
            mState    = waiting;
            mWaitLeft = 2; // two cycles spent in waiting
        end
    endtask

    task automatic advance();
        @(posedge clk);
        if (rstN) begin
            modelEdge();
        end
        #1; // inputs change just after the edge
    endtask

    task automatic driveQuiet(logic start);
        startProcess = start;
        redirect     = '0;
        exLoad       = '0;
        holdNow      = 1'b0;
    endtask

    task automatic driveRandom(input int step, output string name);
        decodedT cur;
        logic    expStall;
        cur             = refDecode(mIfId);
        startProcess    = 1'b0;
        redirect.taken  = ($urandom_range(0, 9) == 0);
        redirect.target = xlenT'($urandom_range(0, progWords - 1) * 4);
        exLoad.memRead  = ($urandom_range(0, 4) == 0);
        if ($urandom_range(0, 1) == 0) begin
            exLoad.rd = ($urandom_range(0, 1) == 0) ? cur.rs1 : cur.rs2;
        end else begin
            exLoad.rd = regAddrT'($urandom_range(0, 31));
        end
        if (step % 25 == 24) begin
            // aim a flush at a live load-use
            redirect.taken = 1'b1;
            exLoad.memRead = 1'b1;
            exLoad.rd      = (cur.rs1 != 5'd0) ? cur.rs1 : cur.rs2;
        end
        if (mPc >= lastPc) begin
            redirect.taken = 1'b1; // next word would leave the program
        end
        expStall = loadUseStall(cur, exLoad);
        holdNow  = expStall && !redirect.taken;
        if (redirect.taken && expStall) begin
            name = "flushOverStall";
            flushCount++;
        end else if (redirect.taken) begin
            name = "redirect";
        end else if (expStall) begin
            name = "loadUseStall";
        end else begin
            name = "sequential";
        end
        redirectCount += int'(redirect.taken);
        stallCount    += int'(expStall);
    endtask

    // decoded reflects the last edge and stall the inputs of this cycle
    task automatic checkOutputs(string decName, string stName);
        decodedT expDec;
        logic    expStall;
        expDec   = refDecode(mIfId);
        expStall = loadUseStall(expDec, exLoad);
        checkCount++;
        assert (decoded === expDec) else begin
            errCount++;
            $display("FAIL %s decoded expected %h actual %h", decName, expDec, decoded);
        end
        assert (stall === expStall) else begin
            errCount++;
            $display("FAIL %s stall expected %b actual %b", stName, expStall, stall);
        end
        if (holdPrev) begin
            assert (decoded === prevDecoded) else begin
                errCount++;
                $display("FAIL %s hold expected %h actual %h", decName, prevDecoded, decoded);
            end
        end
        prevDecoded = expDec;
        holdPrev    = holdNow;
    endtask

    initial begin
        string lastName;
        string curName;
        rstN          = 1'b0;
        startProcess  = 1'b0;
        redirect      = '0;
        exLoad        = '0;
        errCount      = 0;
        checkCount    = 0;
        redirectCount = 0;
        stallCount    = 0;
        flushCount    = 0;
        holdNow       = 1'b0;
        holdPrev      = 1'b0;
        prevDecoded   = '0;
        mState        = idle;
        mWaitLeft     = 0;
        mPc           = resetPc;
        mFetch        = bubble;
        mIfId         = bubble;
        void'($urandom(27));
        $readmemh("sim/program.hex", progMem, 0, progWords - 1);

        for (int i = 0; i < 3; i++) begin
            advance();
            if (i == 2) begin
                rstN = 1'b1; // released just after the third edge
            end
            #4;
            checkOutputs("reset", "reset");
        end
        repeat (2) begin
            advance();
            driveQuiet(1'b0);
            #4;
            checkOutputs("idle", "idle");
        end
        advance();
        driveQuiet(1'b1); // single start pulse
        #4;
        checkOutputs("idle", "startup");
        repeat (3) begin
            advance();
            driveQuiet(1'b0);
            #4;
            checkOutputs("startup", "startup");
        end

        lastName = "startup";
        for (int i = 0; i < numSteps; i++) begin
            advance();
            driveRandom(i, curName);
            #4;
            checkOutputs(lastName, curName);
            lastName = curName;
        end

        assert (redirectCount > 0 && stallCount > 0) else begin
            errCount++;
            $display("random stimulus never produced both a redirect and a load-use stall");
        end
        assert (flushCount > 0) else begin
            errCount++;
            $display("no redirect ever arrived together with a load-use stall");
        end

        $display("checks %0d redirects %0d stalls %0d flushOverStall %0d errors %0d",
                 checkCount, redirectCount, stallCount, flushCount, errCount);
        if (errCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/fetchDecodeTop.sv
`timescale 1ns/10ps

module fetchDecodeTop (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    startProcess,
    input  rvFrontendPkg::redirectT redirect,   // branch/jump resolved in EX
    input  rvFrontendPkg::exLoadT   exLoad,     // load currently in EX
    output rvFrontendPkg::decodedT  decoded,
    output logic                    stall
);
    import rvFrontendPkg::*;

    xlenT  nextPc;
    fetchT fetch;     // registered memory output
    fetchT ifIdOut;
    logic  run;
    logic  ifIdWrite; // inverse of stall

    pcGenerator pcGenerator_inst (
        .clk       (clk),
        .rstN      (rstN),
        .run       (run),
        .redirect  (redirect),
        .ifIdWrite (ifIdWrite),
        .nextPc    (nextPc)
    );

    instructionMemory instructionMemory_inst (
        .clk    (clk),
        .rstN   (rstN),
        .nextPc (nextPc),
        .fetch  (fetch)
    );

    pipelineRegisterIfId pipelineRegisterIfId_inst (
        .clk          (clk),
        .rstN         (rstN),
        .startProcess (startProcess),
        .fetch        (fetch),
        .ifIdWrite    (ifIdWrite),
        .redirect     (redirect),
        .run          (run),
        .ifIdOut      (ifIdOut)
    );

    // decode is combinational off the IF/ID register
    instructionDecoder instructionDecoder_inst (
        .ifIdOut (ifIdOut),
        .decoded (decoded)
    );

    hazardDetection hazardDetection_inst (
        .decoded   (decoded),
        .exLoad    (exLoad),
        .stall     (stall),
        .ifIdWrite (ifIdWrite)
    );

endmodule

// File: rtl/hazardDetection.sv
`timescale 1ns/10ps

module hazardDetection (
    input  rvFrontendPkg::decodedT decoded,
    input  rvFrontendPkg::exLoadT  exLoad,
    output logic                   stall,
    output logic                   ifIdWrite
);
    import rvFrontendPkg::*;

    logic srcMatch; // EX load target feeds a decode source
    logic rdLive;   // x0 never creates a dependency

    assign srcMatch = (exLoad.rd == decoded.rs1) || (exLoad.rd == decoded.rs2);
    assign rdLive   = (exLoad.rd != regAddrT'(0));

    // load-use, data arrives one cycle too late to forward
    assign stall     = exLoad.memRead && rdLive && srcMatch;
    assign ifIdWrite = !stall;

endmodule

// File: rtl/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder (
    input  rvFrontendPkg::fetchT   ifIdOut,
    output rvFrontendPkg::decodedT decoded
);
    import rvFrontendPkg::*;

    instrT ins;
    xlenT  immI;
    xlenT  immS;
    xlenT  immB;
    xlenT  immU;
    xlenT  immJ;

    assign ins = ifIdOut.instr;

    // all formats built in parallel, opcode picks one
    // sign bit is always inst[31]
    assign immI = {{20{ins[31]}}, ins[31:20]};
    assign immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign immU = {ins[31:12], 12'b0};
    assign immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        decoded.pc     = ifIdOut.pc;
        decoded.opcode = ins[6:0];
        decoded.rd     = ins[11:7];
        decoded.funct3 = ins[14:12];
        decoded.rs1    = ins[19:15];
        decoded.rs2    = ins[24:20];
        decoded.funct7 = ins[31:25];

        case (ins[6:0])
            opLoad, opOpImm, opJalr: begin
                decoded.imm = immI;
            end
            opStore: begin
                decoded.imm = immS;
            end
            opBranch: begin
                decoded.imm = immB; // byte offset, lsb zero
            end
            opLui, opAuipc: begin
                decoded.imm = immU;
            end
            opJal: begin
                decoded.imm = immJ;
            end
            opOp: begin
                decoded.imm = '0; // register-register, no immediate
            end
            default: begin
                decoded.imm = '0;
            end
        endcase
    end

endmodule

// File: rtl/pipelineRegisterIfId.sv
`timescale 1ns/10ps

module pipelineRegisterIfId (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    startProcess,
    input  rvFrontendPkg::fetchT    fetch,
    input  logic                    ifIdWrite,
    input  rvFrontendPkg::redirectT redirect,
    output logic                    run,
    output rvFrontendPkg::fetchT    ifIdOut
);
    import rvFrontendPkg::*;

    ifIdStateT  state;
    logic [1:0] waitCnt; // cycles spent in waiting

    // startup sequencing
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= idle;
            waitCnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (startProcess) begin
                        state   <= waiting;
                        waitCnt <= 2'd1; // first waiting cycle starts now
                    end else begin
                        waitCnt <= '0;
                    end
                end
                waiting: begin
                    if (waitCnt == startWait) begin
                        state <= working; // counter parks here
                    end else begin
                        waitCnt <= waitCnt + 2'd1;
                    end
                end
                working: begin
                    state <= working; // stays until reset
                end
                default: begin
                    state   <= idle;
                    waitCnt <= '0;
                end
            endcase
        end
    end

    assign run = (state == working);

    // IF/ID register
    // flush wins over stall, stall wins over capture
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ifIdOut <= nopFetch;
        end else if (run) begin
            if (redirect.taken) begin
                ifIdOut <= nopFetch;  // bubble for the wrong-path word
            end else if (!ifIdWrite) begin
                ifIdOut <= ifIdOut;   // load-use stall, retain
            end else begin
                ifIdOut <= fetch;
            end
        end
    end

endmodule

// File: rtl/instructionMemory.sv
`timescale 1ns/10ps

module instructionMemory (
    input  logic                 clk,
    input  logic                 rstN,
    input  rvFrontendPkg::xlenT  nextPc,
    output rvFrontendPkg::fetchT fetch
);
    import rvFrontendPkg::*;

    instrT    mem [imemDepth]; // program ROM
    imemAddrT rdAddr;

    initial begin
        $readmemh("sim/program.hex", mem);
    end

    assign rdAddr = nextPc[imemAddrW+1:2]; // word index, bits 9:2

    // synchronous read, address registered alongside its word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetch <= nopFetch;
        end else begin
            fetch.pc    <= nextPc;
            fetch.instr <= mem[rdAddr];
        end
    end

endmodule

// File: rtl/pcGenerator.sv
`timescale 1ns/10ps

module pcGenerator (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    run,        // IF/ID in working state
    input  rvFrontendPkg::redirectT redirect,
    input  logic                    ifIdWrite,  // low while load-use stall
    output rvFrontendPkg::xlenT     nextPc
);
    import rvFrontendPkg::*;

    xlenT pc; // address of the word currently held by the fetch register

    // next-PC select, redirect first, then stall, then sequential
    always_comb begin
        if (!run) begin
            nextPc = resetPc; // keep refetching word 0 until the pipe runs
        end else if (redirect.taken) begin
            nextPc = redirect.target;
        end else if (!ifIdWrite) begin
            nextPc = pc; // hold, memory rereads the same word
        end else begin
            nextPc = pc + xlenT'(4);
        end
    end

    // pc and the memory output register load on the same edge,
    // so pc always matches fetch.pc
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: rtl/rvFrontendPkg.sv
package rvFrontendPkg;

    // base widths
    localparam int xlenW    = 32;
    localparam int instrW   = 32;
    localparam int regAddrW = 5;

    // instruction memory geometry, 256 words
    localparam int imemDepth = 256;
    localparam int imemAddrW = $clog2(imemDepth); // word index, byte bits dropped

    typedef logic [xlenW-1:0]     xlenT;     // pc or address
    typedef logic [instrW-1:0]    instrT;    // one instruction word
    typedef logic [regAddrW-1:0]  regAddrT;  // x0..x31
    typedef logic [imemAddrW-1:0] imemAddrT;

    localparam instrT nopInstr = 32'h0000_0013; // addi x0,x0,0
    localparam xlenT  resetPc  = '0;

    // cycles spent in waiting after startProcess
    localparam logic [1:0] startWait = 2'd2;

    // major opcodes, inst[6:0]
    localparam logic [6:0] opLoad   = 7'b000_0011;
    localparam logic [6:0] opStore  = 7'b010_0011;
    localparam logic [6:0] opOpImm  = 7'b001_0011;
    localparam logic [6:0] opOp     = 7'b011_0011;
    localparam logic [6:0] opBranch = 7'b110_0011;
    localparam logic [6:0] opLui    = 7'b011_0111;
    localparam logic [6:0] opAuipc  = 7'b001_0111;
    localparam logic [6:0] opJal    = 7'b110_1111;
    localparam logic [6:0] opJalr   = 7'b110_0111;

    typedef struct packed {
        xlenT  pc;
        instrT instr;
    } fetchT; // 64 bits

    // bubble pair used on reset and on flush
    localparam fetchT nopFetch = '{pc: '0, instr: nopInstr};

    typedef struct packed {
        logic taken;
        xlenT target;
    } redirectT; // from EX, 33 bits

    typedef struct packed {
        logic    memRead;
        regAddrT rd;
    } exLoadT; // instruction sitting in EX

    typedef struct packed {
        xlenT       pc;
        logic [6:0] opcode;
        regAddrT    rd;
        regAddrT    rs1;
        regAddrT    rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        xlenT       imm;
    } decodedT; // 96 bits

    typedef enum logic [1:0] {
        idle,
        waiting,
        working
    } ifIdStateT;

endpackage
